// ==== source/gpio_pkg.sv ====
// Shared constants for the digital I/O peripheral
//   Bus and port widths
//   Register offsets inside a port block
//   Byte base addresses of ports 1 and 2

package gpio_pkg;

  //----------------------------------------------------------------------
  // Bus widths
  //----------------------------------------------------------------------

  localparam ADDR_W = 8;            // Peripheral word address
  localparam DATA_W = 16;           // Peripheral data bus

  //----------------------------------------------------------------------
  // Port geometry
  //----------------------------------------------------------------------

  localparam PORT_W   = 8;          // Pins per port
  localparam NUM_REGS = 7;

  // Register offsets inside a port block
  // Even offsets live in the low byte lane, odd ones in the high lane
  localparam REG_IN  = 0;           // Sampled pins, read only
  localparam REG_OUT = 1;
  localparam REG_DIR = 2;           // Output enables
  localparam REG_IFG = 3;
  localparam REG_IES = 4;           // 1 selects the falling edge
  localparam REG_IE  = 5;
  localparam REG_SEL = 6;

  //----------------------------------------------------------------------
  // Port block byte addresses
  //----------------------------------------------------------------------

  // Each block is eight bytes wide and aligned on eight bytes
  localparam logic [8:0] P1_BASE = 9'h020;
  localparam logic [8:0] P2_BASE = 9'h028;

endpackage

// ==== source/gpio_bus_decoder.sv ====
// Peripheral bus decoder for the I/O ports
//   Matches the word address against both port blocks
//   Builds per-register write and read strobes
//   Merges the port read words onto the bus

`timescale 1ns/1ps

module gpio_bus_decoder (
  input  logic                          per_en,
  input  logic [1:0]                    per_wen,
  input  logic [gpio_pkg::ADDR_W-1:0]   per_addr,
  input  logic [gpio_pkg::DATA_W-1:0]   p1_rdata,
  input  logic [gpio_pkg::DATA_W-1:0]   p2_rdata,
  output logic [gpio_pkg::NUM_REGS-1:0] p1_wr,
  output logic [gpio_pkg::NUM_REGS-1:0] p1_rd,
  output logic [gpio_pkg::NUM_REGS-1:0] p2_wr,
  output logic [gpio_pkg::NUM_REGS-1:0] p2_rd,
  output logic [gpio_pkg::DATA_W-1:0]   per_dout
);

  import gpio_pkg::*;

  // Strobes for the registers held in the addressed word
  // Each register is qualified by the enable of its own byte lane
  function automatic logic [NUM_REGS-1:0] lane_strobes(input logic hit,
                                                       input logic [1:0] woff,
                                                       input logic lo_en,
                                                       input logic hi_en,
                                                       input logic is_wr);
    logic [NUM_REGS-1:0] s;
    for (int r = 0; r < NUM_REGS; r++) begin
      s[r] = hit && (woff == 2'(r / 2)) && ((r % 2 == 1) ? hi_en : lo_en);
      if (is_wr && r == REG_IN) begin
        s[r] = 1'b0;                // IN only follows the pins
      end
    end
    return s;
  endfunction

  //----------------------------------------------------------------------
  // Access type and block match
  //----------------------------------------------------------------------

  logic       wr_lo;
  logic       wr_hi;
  logic       rd_acc;
  logic       p1_hit;
  logic       p2_hit;
  logic [1:0] word_off;

  assign wr_lo  = per_en & per_wen[0];
  assign wr_hi  = per_en & per_wen[1];
  assign rd_acc = per_en & ~|per_wen;

  // Blocks are 8-byte aligned, so the upper word address bits pick the port
  assign p1_hit   = (per_addr[ADDR_W-1:2] == P1_BASE[ADDR_W:3]);
  assign p2_hit   = (per_addr[ADDR_W-1:2] == P2_BASE[ADDR_W:3]);
  assign word_off = per_addr[1:0];

  assign p1_wr = lane_strobes(p1_hit, word_off, wr_lo, wr_hi, 1'b1);
  assign p2_wr = lane_strobes(p2_hit, word_off, wr_lo, wr_hi, 1'b1);
  assign p1_rd = lane_strobes(p1_hit, word_off, rd_acc, rd_acc, 1'b0);
  assign p2_rd = lane_strobes(p2_hit, word_off, rd_acc, rd_acc, 1'b0);

  // Unselected ports return zero, so a plain OR is the read mux
  assign per_dout = p1_rdata | p2_rdata;

  //----------------------------------------------------------------------
  // Checks
  //----------------------------------------------------------------------

  always_comb begin
    // At most one register per lane, i.e. a single word
    a_one_word: assert final ($countones(p1_wr | p1_rd) <= 2 &&
                              $countones(p2_wr | p2_rd) <= 2);
    a_no_mix: assert final (!(|(p1_wr | p2_wr) && |(p1_rd | p2_rd)));
  end

endmodule

// ==== source/gpio_irq_port.sv ====
// Interrupt-capable 8-bit I/O port
//   IN, OUT, DIR, IFG, IES, IE and SEL registers
//   Per-bit edge detection with selectable edge
//   Lane-placed read word and port interrupt line

`timescale 1ns/1ps

module gpio_irq_port (
  input  logic                          mclk,
  input  logic                          puc,
  input  logic [gpio_pkg::NUM_REGS-1:0] wr,
  input  logic [gpio_pkg::NUM_REGS-1:0] rd,
  input  logic [gpio_pkg::DATA_W-1:0]   per_din,
  input  logic [gpio_pkg::PORT_W-1:0]   pin_din,
  output logic [gpio_pkg::PORT_W-1:0]   pin_dout,
  output logic [gpio_pkg::PORT_W-1:0]   pin_dout_en,
  output logic [gpio_pkg::PORT_W-1:0]   pin_sel,
  output logic [gpio_pkg::DATA_W-1:0]   rdata,
  output logic                          irq
);

  import gpio_pkg::*;

  logic [PORT_W-1:0] din_q;         // IN register
  logic [PORT_W-1:0] din_dly;       // IN one cycle later
  logic [PORT_W-1:0] dout_q;
  logic [PORT_W-1:0] dir_q;
  logic [PORT_W-1:0] ifg_q;
  logic [PORT_W-1:0] ies_q;
  logic [PORT_W-1:0] ie_q;
  logic [PORT_W-1:0] sel_q;

  //----------------------------------------------------------------------
  // Write data
  //----------------------------------------------------------------------

  logic [PORT_W-1:0] lo_byte;
  logic [PORT_W-1:0] hi_byte;

  assign lo_byte = per_din[PORT_W-1:0];
  assign hi_byte = per_din[DATA_W-1:PORT_W];

  // Lane comes from the parity of each register offset
  logic [PORT_W-1:0] out_nxt;
  logic [PORT_W-1:0] dir_nxt;
  logic [PORT_W-1:0] ifg_nxt;
  logic [PORT_W-1:0] ies_nxt;
  logic [PORT_W-1:0] ie_nxt;
  logic [PORT_W-1:0] sel_nxt;

  assign out_nxt = REG_OUT[0] ? hi_byte : lo_byte;
  assign dir_nxt = REG_DIR[0] ? hi_byte : lo_byte;
  assign ifg_nxt = REG_IFG[0] ? hi_byte : lo_byte;
  assign ies_nxt = REG_IES[0] ? hi_byte : lo_byte;
  assign ie_nxt  = REG_IE[0]  ? hi_byte : lo_byte;
  assign sel_nxt = REG_SEL[0] ? hi_byte : lo_byte;

  //----------------------------------------------------------------------
  // Registers
  //----------------------------------------------------------------------

  always_ff @(posedge mclk or posedge puc) begin
    if (puc) begin
      dout_q <= '0;
      dir_q  <= '0;
      ies_q  <= '0;
      ie_q   <= '0;
      sel_q  <= '0;
    end else begin
      if (wr[REG_OUT]) dout_q <= out_nxt;
      if (wr[REG_DIR]) dir_q  <= dir_nxt;
      if (wr[REG_IES]) ies_q  <= ies_nxt;
      if (wr[REG_IE])  ie_q   <= ie_nxt;
      if (wr[REG_SEL]) sel_q  <= sel_nxt;
    end
  end

  // Pin sampling and its delayed copy for edge detection
  always_ff @(posedge mclk or posedge puc) begin
    if (puc) begin
      din_q   <= '0;
      din_dly <= '0;
    end else begin
      din_q   <= pin_din;
      din_dly <= din_q;
    end
  end

  //----------------------------------------------------------------------
  // Edge detection and interrupt flags
  //----------------------------------------------------------------------

  logic [PORT_W-1:0] rise;
  logic [PORT_W-1:0] fall;
  logic [PORT_W-1:0] ifg_set;

  assign rise    =  din_q & ~din_dly;
  assign fall    = ~din_q &  din_dly;
  assign ifg_set = (ies_q & fall) | (~ies_q & rise);   // Edge picked per bit

  // A flag edge is never lost, even during a software write
  always_ff @(posedge mclk or posedge puc) begin
    if (puc) begin
      ifg_q <= '0;
    end else if (wr[REG_IFG]) begin
      ifg_q <= ifg_nxt | ifg_set;
    end else begin
      ifg_q <= ifg_q | ifg_set;
    end
  end

  assign irq = |(ie_q & ifg_q);

  assign pin_dout    = dout_q;
  assign pin_dout_en = dir_q;
  assign pin_sel     = sel_q;

  //----------------------------------------------------------------------
  // Read word
  //----------------------------------------------------------------------

  logic [PORT_W-1:0] reg_val [NUM_REGS];

  assign reg_val[REG_IN]  = din_q;
  assign reg_val[REG_OUT] = dout_q;
  assign reg_val[REG_DIR] = dir_q;
  assign reg_val[REG_IFG] = ifg_q;
  assign reg_val[REG_IES] = ies_q;
  assign reg_val[REG_IE]  = ie_q;
  assign reg_val[REG_SEL] = sel_q;

  always_comb begin
    rdata = '0;
    for (int r = 0; r < NUM_REGS; r++) begin
      if (rd[r]) begin
        if (r % 2 == 1) begin
          rdata[DATA_W-1:PORT_W] = rdata[DATA_W-1:PORT_W] | reg_val[r];
        end else begin
          rdata[PORT_W-1:0] = rdata[PORT_W-1:0] | reg_val[r];
        end
      end
    end
  end

  //----------------------------------------------------------------------
  // Checks
  //----------------------------------------------------------------------

  // irq only rises after a caught edge or a write to IFG or IE
  a_irq_cause: assert property (@(posedge mclk) disable iff (puc)
    $rose(irq) |-> $past(|ifg_set || wr[REG_IFG] || wr[REG_IE]));

  a_irq_reset: assert property (@(posedge mclk) puc |-> !irq);

endmodule

// ==== source/gpio.sv ====
// Digital I/O peripheral top level
//   Bus decoder and two interrupt-capable 8-bit ports

`timescale 1ns/1ps

module gpio (
  input  logic                        mclk,
  input  logic                        puc,
  input  logic                        per_en,
  input  logic [1:0]                  per_wen,
  input  logic [gpio_pkg::ADDR_W-1:0] per_addr,
  input  logic [gpio_pkg::DATA_W-1:0] per_din,
  input  logic [gpio_pkg::PORT_W-1:0] p1_din,
  input  logic [gpio_pkg::PORT_W-1:0] p2_din,
  output logic [gpio_pkg::DATA_W-1:0] per_dout,
  output logic [gpio_pkg::PORT_W-1:0] p1_dout,
  output logic [gpio_pkg::PORT_W-1:0] p1_dout_en,
  output logic [gpio_pkg::PORT_W-1:0] p1_sel,
  output logic [gpio_pkg::PORT_W-1:0] p2_dout,
  output logic [gpio_pkg::PORT_W-1:0] p2_dout_en,
  output logic [gpio_pkg::PORT_W-1:0] p2_sel,
  output logic                        irq_port1,
  output logic                        irq_port2
);

  import gpio_pkg::*;

  logic [NUM_REGS-1:0] p1_wr;       // Register strobes per port
  logic [NUM_REGS-1:0] p1_rd;
  logic [NUM_REGS-1:0] p2_wr;
  logic [NUM_REGS-1:0] p2_rd;
  logic [DATA_W-1:0]   p1_rdata;    // Lane-placed read words
  logic [DATA_W-1:0]   p2_rdata;

  gpio_bus_decoder bus_dec0 (
    .per_en   (per_en),
    .per_wen  (per_wen),
    .per_addr (per_addr),
    .p1_rdata (p1_rdata),
    .p2_rdata (p2_rdata),
    .p1_wr    (p1_wr),
    .p1_rd    (p1_rd),
    .p2_wr    (p2_wr),
    .p2_rd    (p2_rd),
    .per_dout (per_dout)
  );

  gpio_irq_port port1 (
    .mclk        (mclk),
    .puc         (puc),
    .wr          (p1_wr),
    .rd          (p1_rd),
    .per_din     (per_din),
    .pin_din     (p1_din),
    .pin_dout    (p1_dout),
    .pin_dout_en (p1_dout_en),
    .pin_sel     (p1_sel),
    .rdata       (p1_rdata),
    .irq         (irq_port1)
  );

  gpio_irq_port port2 (
    .mclk        (mclk),
    .puc         (puc),
    .wr          (p2_wr),
    .rd          (p2_rd),
    .per_din     (per_din),
    .pin_din     (p2_din),
    .pin_dout    (p2_dout),
    .pin_dout_en (p2_dout_en),
    .pin_sel     (p2_sel),
    .rdata       (p2_rdata),
    .irq         (irq_port2)
  );

endmodule

// ==== tb/tb_gpio_table.svh ====
// Stimulus and expected values for the GPIO testbench
//   Columns: operation, word address or port, per_wen, data, expected

task automatic load_table();
  // Reset state
  add_row(OP_OUTS, 1, 2'b00, 16'h0000, 24'h000000);
  add_row(OP_OUTS, 2, 2'b00, 16'h0000, 24'h000000);
  add_row(OP_IRQ, 1, 2'b00, 16'h0000, 24'h0);
  add_row(OP_IRQ, 2, 2'b00, 16'h0000, 24'h0);
  add_row(OP_RD, P1_IN_OUT, 2'b00, 16'h0000, 24'h0000);
  add_row(OP_RD, P1_DIR_IFG, 2'b00, 16'h0000, 24'h0000);
  add_row(OP_RD, P1_IES_IE, 2'b00, 16'h0000, 24'h0000);
  add_row(OP_RD, P1_SEL_W, 2'b00, 16'h0000, 24'h0000);
  add_row(OP_RD, P2_IN_OUT, 2'b00, 16'h0000, 24'h0000);
  add_row(OP_RD, P2_DIR_IFG, 2'b00, 16'h0000, 24'h0000);
  add_row(OP_RD, P2_IES_IE, 2'b00, 16'h0000, 24'h0000);
  add_row(OP_RD, P2_SEL_W, 2'b00, 16'h0000, 24'h0000);

  // Output registers, one lane at a time
  add_row(OP_WR, P1_IN_OUT, 2'b10, 16'hA53C, 24'h0);   // OUT only
  add_row(OP_WR, P1_DIR_IFG, 2'b01, 16'hFF0F, 24'h0);  // DIR only
  add_row(OP_WR, P1_SEL_W, 2'b01, 16'h0081, 24'h0);
  add_row(OP_OUTS, 1, 2'b00, 16'h0000, 24'h810FA5);
  add_row(OP_RD, P1_IN_OUT, 2'b00, 16'h0000, 24'hA500);
  add_row(OP_RD, P1_DIR_IFG, 2'b00, 16'h0000, 24'h000F);
  add_row(OP_RD, P1_SEL_W, 2'b00, 16'h0000, 24'h0081);
  add_row(OP_WR, P2_IN_OUT, 2'b11, 16'h5A77, 24'h0);   // IN ignores the low byte
  add_row(OP_WR, P2_DIR_IFG, 2'b01, 16'h00F0, 24'h0);
  add_row(OP_WR, P2_SEL_W, 2'b11, 16'hFF3C, 24'h0);
  add_row(OP_OUTS, 2, 2'b00, 16'h0000, 24'h3CF05A);
  add_row(OP_RD, P2_IN_OUT, 2'b00, 16'h0000, 24'h5A00);
  add_row(OP_RD, P2_SEL_W, 2'b00, 16'h0000, 24'h003C);

  // Random pins read back from IN, expected column is the OUT byte
  add_row(OP_RAND, 1, 2'b00, 16'h0000, 24'hA5);
  add_row(OP_RAND, 1, 2'b00, 16'h0000, 24'hA5);
  add_row(OP_RAND, 1, 2'b00, 16'h0000, 24'hA5);
  add_row(OP_RAND, 2, 2'b00, 16'h0000, 24'h5A);
  add_row(OP_RAND, 2, 2'b00, 16'h0000, 24'h5A);
  add_row(OP_RAND, 2, 2'b00, 16'h0000, 24'h5A);
  add_row(OP_PINS, 1, 2'b00, 16'h0000, 24'h0);
  add_row(OP_PINS, 2, 2'b00, 16'h0000, 24'h0);
  add_row(OP_IDLE, 0, 2'b00, 16'd3, 24'h0);
  add_row(OP_WR, P1_DIR_IFG, 2'b10, 16'h0000, 24'h0);  // Drop flags left by random edges
  add_row(OP_WR, P2_DIR_IFG, 2'b10, 16'h0000, 24'h0);
  add_row(OP_RD, P1_DIR_IFG, 2'b00, 16'h0000, 24'h000F);
  add_row(OP_RD, P2_DIR_IFG, 2'b00, 16'h0000, 24'h00F0);

  // Rising edge with IE set
  add_row(OP_WR, P1_IES_IE, 2'b10, 16'h0100, 24'h0);
  add_row(OP_PINS, 1, 2'b00, 16'h0001, 24'h0);
  add_row(OP_IRQ_WAIT, 1, 2'b00, 16'h0000, 24'h0);
  add_row(OP_RD, P1_DIR_IFG, 2'b00, 16'h0000, 24'h010F);
  add_row(OP_IRQ, 2, 2'b00, 16'h0000, 24'h0);
  add_row(OP_WR, P1_DIR_IFG, 2'b10, 16'h0000, 24'h0);
  add_row(OP_IRQ, 1, 2'b00, 16'h0000, 24'h0);

  // Bit 1 flags without IE, then bit 0 falls with IES set
  add_row(OP_WR, P1_IES_IE, 2'b01, 16'h0001, 24'h0);
  add_row(OP_RD, P1_IES_IE, 2'b00, 16'h0000, 24'h0101);
  add_row(OP_PINS, 1, 2'b00, 16'h0003, 24'h0);
  add_row(OP_IDLE, 0, 2'b00, 16'd2, 24'h0);
  add_row(OP_RD, P1_DIR_IFG, 2'b00, 16'h0000, 24'h020F);
  add_row(OP_IRQ, 1, 2'b00, 16'h0000, 24'h0);
  add_row(OP_PINS, 1, 2'b00, 16'h0002, 24'h0);
  add_row(OP_IRQ_WAIT, 1, 2'b00, 16'h0000, 24'h0);
  add_row(OP_RD, P1_DIR_IFG, 2'b00, 16'h0000, 24'h030F);

  // Rising edge ignored while IES is set
  add_row(OP_WR, P1_DIR_IFG, 2'b10, 16'h0000, 24'h0);
  add_row(OP_IRQ, 1, 2'b00, 16'h0000, 24'h0);
  add_row(OP_PINS, 1, 2'b00, 16'h0003, 24'h0);
  add_row(OP_IDLE, 0, 2'b00, 16'd2, 24'h0);
  add_row(OP_RD, P1_DIR_IFG, 2'b00, 16'h0000, 24'h000F);
  add_row(OP_IRQ, 1, 2'b00, 16'h0000, 24'h0);

  // Flags set by software
  add_row(OP_WR, P1_DIR_IFG, 2'b10, 16'h0100, 24'h0);
  add_row(OP_IRQ, 1, 2'b00, 16'h0000, 24'h1);
  add_row(OP_RD, P1_DIR_IFG, 2'b00, 16'h0000, 24'h010F);
  add_row(OP_WR, P1_DIR_IFG, 2'b10, 16'h0000, 24'h0);
  add_row(OP_IRQ, 1, 2'b00, 16'h0000, 24'h0);

  // Port 2 interrupt line
  add_row(OP_WR, P2_IES_IE, 2'b10, 16'h8000, 24'h0);
  add_row(OP_PINS, 2, 2'b00, 16'h0080, 24'h0);
  add_row(OP_IRQ_WAIT, 2, 2'b00, 16'h0000, 24'h0);
  add_row(OP_IRQ, 1, 2'b00, 16'h0000, 24'h0);
  add_row(OP_WR, P2_DIR_IFG, 2'b10, 16'h0000, 24'h0);
  add_row(OP_IRQ, 2, 2'b00, 16'h0000, 24'h0);
  add_row(OP_WR, P2_DIR_IFG, 2'b10, 16'h0100, 24'h0);  // Flag on a disabled bit
  add_row(OP_IRQ, 2, 2'b00, 16'h0000, 24'h0);
  add_row(OP_RD, P2_DIR_IFG, 2'b00, 16'h0000, 24'h01F0);
  add_row(OP_WR, P2_DIR_IFG, 2'b10, 16'h0000, 24'h0);

  // Unmapped locations
  add_row(OP_RD, P1_SEL_W, 2'b00, 16'h0000, 24'h0081);  // Byte 0x027 reads zero
  add_row(OP_WR, P1_SEL_W, 2'b10, 16'hFFFF, 24'h0);
  add_row(OP_RD, P1_SEL_W, 2'b00, 16'h0000, 24'h0081);
  add_row(OP_RD, P2_SEL_W, 2'b00, 16'h0000, 24'h003C);
  add_row(OP_WR, 8'h00, 2'b11, 16'hFFFF, 24'h0);
  add_row(OP_RD, 8'h00, 2'b00, 16'h0000, 24'h0000);
  add_row(OP_WR, 8'h18, 2'b11, 16'hFFFF, 24'h0);
  add_row(OP_RD, 8'h18, 2'b00, 16'h0000, 24'h0000);
  add_row(OP_OUTS, 1, 2'b00, 16'h0000, 24'h810FA5);
  add_row(OP_OUTS, 2, 2'b00, 16'h0000, 24'h3CF05A);
  add_row(OP_RD, P1_IN_OUT, 2'b00, 16'h0000, 24'hA503);
  add_row(OP_RD, P2_IN_OUT, 2'b00, 16'h0000, 24'h5A80);
endtask

// ==== tb/tb_gpio.sv ====
// Testbench for the digital I/O peripheral
//   Clock, reset and DUT instance
//   Compare tasks for bus words, pin outputs and interrupt lines
//   Loop that applies the stimulus table

`timescale 1ns/1ps

module tb_gpio;

  import gpio_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int TABLE_MAX   = 100;
  localparam int IRQ_TIMEOUT = 20;      // Cycles

  // Table operations
  localparam logic [3:0] OP_WR       = 4'd0;
  localparam logic [3:0] OP_RD       = 4'd1;
  localparam logic [3:0] OP_PINS     = 4'd2;  // Address field holds the port number
  localparam logic [3:0] OP_RAND     = 4'd3;
  localparam logic [3:0] OP_IDLE     = 4'd4;
  localparam logic [3:0] OP_OUTS     = 4'd5;  // Expected {sel, dout_en, dout}
  localparam logic [3:0] OP_IRQ      = 4'd6;
  localparam logic [3:0] OP_IRQ_WAIT = 4'd7;

  // Word addresses of the register pairs
  localparam logic [ADDR_W-1:0] P1_IN_OUT  = P1_BASE[ADDR_W:1];
  localparam logic [ADDR_W-1:0] P1_DIR_IFG = P1_IN_OUT + 1;
  localparam logic [ADDR_W-1:0] P1_IES_IE  = P1_IN_OUT + 2;
  localparam logic [ADDR_W-1:0] P1_SEL_W   = P1_IN_OUT + 3;
  localparam logic [ADDR_W-1:0] P2_IN_OUT  = P2_BASE[ADDR_W:1];
  localparam logic [ADDR_W-1:0] P2_DIR_IFG = P2_IN_OUT + 1;
  localparam logic [ADDR_W-1:0] P2_IES_IE  = P2_IN_OUT + 2;
  localparam logic [ADDR_W-1:0] P2_SEL_W   = P2_IN_OUT + 3;

  logic              mclk;
  logic              puc;
  logic              per_en;
  logic [1:0]        per_wen;
  logic [ADDR_W-1:0] per_addr;
  logic [DATA_W-1:0] per_din;
  logic [DATA_W-1:0] per_dout;
  logic [PORT_W-1:0] p1_din;
  logic [PORT_W-1:0] p2_din;
  logic [PORT_W-1:0] p1_dout;
  logic [PORT_W-1:0] p1_dout_en;
  logic [PORT_W-1:0] p1_sel;
  logic [PORT_W-1:0] p2_dout;
  logic [PORT_W-1:0] p2_dout_en;
  logic [PORT_W-1:0] p2_sel;
  logic              irq_port1;
  logic              irq_port2;

  integer            seed;
  int                n_rows;
  logic [3:0]        row_op   [TABLE_MAX];
  logic [ADDR_W-1:0] row_addr [TABLE_MAX];
  logic [1:0]        row_wen  [TABLE_MAX];
  logic [DATA_W-1:0] row_data [TABLE_MAX];
  logic [23:0]       row_exp  [TABLE_MAX];

  gpio dut0 (.*);

  initial begin
    mclk = 1'b0;
    forever #(CLK_PERIOD / 2) mclk = ~mclk;
  end

  //--------------------------------------------------------------------
  // Reporting and compare tasks
  //--------------------------------------------------------------------

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_pins(input logic [PORT_W-1:0] got, input logic [PORT_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_irq(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  //--------------------------------------------------------------------
  // Table building and bus helpers
  //--------------------------------------------------------------------

  task automatic add_row(input logic [3:0] op, input logic [ADDR_W-1:0] addr,
                         input logic [1:0] wen, input logic [DATA_W-1:0] data,
                         input logic [23:0] exp);
    if (n_rows >= TABLE_MAX) begin
      abort_run("The stimulus table has more rows than it can hold");
    end else begin
      row_op[n_rows]   = op;
      row_addr[n_rows] = addr;
      row_wen[n_rows]  = wen;
      row_data[n_rows] = data;
      row_exp[n_rows]  = exp;
      n_rows++;
    end
  endtask

  `include "tb_gpio_table.svh"

  task automatic bus_idle();
    per_en   = 1'b0;
    per_wen  = 2'b00;
    per_addr = '0;
    per_din  = '0;
  endtask

  task automatic drive_pins(input int port, input logic [PORT_W-1:0] value);
    if (port == 1) p1_din = value;
    else           p2_din = value;
  endtask

  // Read a word in the middle of the low clock phase
  task automatic read_and_check(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
    per_en   = 1'b1;
    per_wen  = 2'b00;
    per_addr = addr;
    #(CLK_PERIOD / 4);
    check_word(per_dout, exp, $sformatf("read of word %h", addr));
    @(negedge mclk);
    bus_idle();
  endtask

  task automatic wait_irq(input int port);
    int n;
    n = 0;
    while (((port == 1) ? irq_port1 : irq_port2) !== 1'b1) begin
      if (n >= IRQ_TIMEOUT) begin
        abort_run($sformatf("Timed out waiting for the interrupt of port %0d", port));
      end else begin
        @(negedge mclk);
        n++;
      end
    end
  endtask

  //--------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------

  initial begin
    logic [PORT_W-1:0] pins;
    seed   = 93;
    n_rows = 0;
    puc    = 1'b1;
    p1_din = '0;
    p2_din = '0;
    bus_idle();
    load_table();
    repeat (10) @(posedge mclk);
    @(negedge mclk);
    puc = 1'b0;

    for (int i = 0; i < n_rows; i++) begin
      case (row_op[i])
        OP_WR: begin
          per_en   = 1'b1;
          per_wen  = row_wen[i];
          per_addr = row_addr[i];
          per_din  = row_data[i];
          @(negedge mclk);
          bus_idle();
        end
        OP_RD: read_and_check(row_addr[i], row_exp[i][DATA_W-1:0]);
        OP_PINS: begin
          drive_pins(row_addr[i], row_data[i][PORT_W-1:0]);
          @(negedge mclk);
        end
        OP_RAND: begin
          pins = $random(seed);
          drive_pins(row_addr[i], pins);
          @(negedge mclk);        // IN samples at this edge
          read_and_check((row_addr[i] == 1) ? P1_IN_OUT : P2_IN_OUT,
                         {row_exp[i][PORT_W-1:0], pins});
        end
        OP_IDLE: repeat (row_data[i]) @(negedge mclk);
        OP_OUTS: begin
          if (row_addr[i] == 1) begin
            check_pins(p1_dout, row_exp[i][7:0], "p1_dout");
            check_pins(p1_dout_en, row_exp[i][15:8], "p1_dout_en");
            check_pins(p1_sel, row_exp[i][23:16], "p1_sel");
          end else begin
            check_pins(p2_dout, row_exp[i][7:0], "p2_dout");
            check_pins(p2_dout_en, row_exp[i][15:8], "p2_dout_en");
            check_pins(p2_sel, row_exp[i][23:16], "p2_sel");
          end
        end
        OP_IRQ: begin
          if (row_addr[i] == 1) check_irq(irq_port1, row_exp[i][0], "irq_port1");
          else                  check_irq(irq_port2, row_exp[i][0], "irq_port2");
        end
        OP_IRQ_WAIT: wait_irq(row_addr[i]);
        default: abort_run($sformatf("Row %0d holds an unknown operation", i));
      endcase
    end

    $display("Test passed");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+tb
source/gpio_pkg.sv
source/gpio_bus_decoder.sv
source/gpio_irq_port.sv
source/gpio.sv
tb/tb_gpio.sv

// ==== Bender.yml ====
package:
  name: gpio

sources:
  - files:
      - source/gpio_pkg.sv
      - source/gpio_bus_decoder.sv
      - source/gpio_irq_port.sv
      - source/gpio.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_gpio.sv
